// File: Makefile
# Verilator build and run of the ALU testbench.
TOP := tb_alu

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   list these targets"

test:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f flist.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: include/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

typedef struct packed {
    logic       valid;                                // Opcode is one the ALU accepts.
    alu_word_t  res;
    alu_flags_t flags;
} expect_t;

function automatic logic top_bit(alu_word_t w, logic wide);
    return wide ? w[15] : w[7];
endfunction

function automatic alu_word_t trim(alu_word_t w, logic wide);
    return wide ? w : (w & 16'h00ff);
endfunction

// Expected result and flags of one request.
function automatic expect_t model_alu(alu_req_t r, alu_flags_t fi);
    expect_t     e;
    int          w;
    int          k;
    alu_word_t   a;
    alu_word_t   b;
    alu_word_t   op;
    alu_word_t   m;
    alu_word_t   res;
    alu_flags_t  f;
    logic [4:0]  n;
    logic [16:0] t17;
    logic        fill;
    logic        psz;
    logic        zonly;
    logic        valid;
    logic signed [31:0] sx;

    w     = r.wide ? 16 : 8;
    a     = trim(r.ta, r.wide);
    b     = trim(r.tb, r.wide);
    n     = r.tb[4:0];
    k     = n % w;
    f     = fi;
    res   = a;
    psz   = 1'b0;
    zonly = 1'b0;
    valid = 1'b1;
    op    = b;
    if (r.operation inside {OP_INC, OP_DEC}) op = 16'h0001;
    if (r.operation inside {OP_ADDC, OP_SUBC}) op = b + {15'h0, fi.cy};  // Wraps at 16 bits.
    m    = 16'h0001 << (r.wide ? r.tb[3:0] : {1'b0, r.tb[2:0]});
    fill = 1'b0;
    case (r.operation)
        OP_ADD, OP_ADDC, OP_INC: begin
            t17 = {1'b0, a} + {1'b0, op};
            res = t17[15:0];
            if (r.operation != OP_INC) f.cy = t17[w];
            f.ac = ({1'b0, a[3:0]} + {1'b0, op[3:0]}) > 5'd15;
            f.v  = (top_bit(a, r.wide) == top_bit(op, r.wide)) &&
                   (top_bit(res, r.wide) != top_bit(a, r.wide));
            psz  = 1'b1;
        end
        OP_SUB, OP_SUBC, OP_CMP, OP_DEC: begin
            res = a - op;
            if (r.operation != OP_DEC) f.cy = op > a;    // Borrow.
            f.ac = op[3:0] > a[3:0];
            f.v  = (top_bit(a, r.wide) != top_bit(op, r.wide)) &&
                   (top_bit(res, r.wide) != top_bit(a, r.wide));
            psz  = 1'b1;
        end
        OP_NEG: begin
            res  = 16'h0000 - a;
            f.cy = a != 16'h0000;
            f.ac = a[3:0] != 4'h0;
            f.v  = a == (r.wide ? 16'h8000 : 16'h0080);
            psz  = 1'b1;
        end
        OP_AND, OP_OR, OP_XOR: begin
            if (r.operation == OP_AND) res = a & r.tb;
            if (r.operation == OP_OR) res = a | r.tb;
            if (r.operation == OP_XOR) res = a ^ r.tb;
            f.cy = 1'b0;
            f.v  = 1'b0;
            f.ac = 1'b0;
            psz  = 1'b1;
        end
        OP_NOT:  res = ~a;
        OP_SET1: res = a | m;
        OP_CLR1: res = a & ~m;
        OP_NOT1: res = a ^ m;
        OP_TEST1: begin
            res   = a & m;
            f.cy  = 1'b0;
            f.v   = 1'b0;
            zonly = 1'b1;
        end
        OP_ROL: begin
            res  = trim((a << k) | (a >> (w - k)), r.wide);
            f.cy = res[0];
        end
        OP_ROR: begin
            res  = trim((a >> k) | (a << (w - k)), r.wide);
            f.cy = top_bit(res, r.wide);
        end
        OP_ROL1, OP_ROLC1, OP_SHL1: begin
            if (r.operation == OP_ROL1) fill = top_bit(a, r.wide);
            if (r.operation == OP_ROLC1) fill = fi.cy;
            res  = (a << 1) | {15'h0, fill};
            f.cy = top_bit(a, r.wide);
            f.v  = top_bit(a, r.wide) ^ a[w-2];
            psz  = r.operation == OP_SHL1;
        end
        OP_ROR1, OP_RORC1, OP_SHR1, OP_SHRA1: begin
            if (r.operation == OP_ROR1) fill = a[0];
            if (r.operation == OP_RORC1) fill = fi.cy;
            if (r.operation == OP_SHRA1) fill = top_bit(a, r.wide);
            res  = (a >> 1) | ({15'h0, fill} << (w - 1));
            f.cy = a[0];
            if (r.operation == OP_ROR1) f.v = top_bit(a, r.wide) ^ a[0];
            if (r.operation == OP_RORC1) f.v = top_bit(a, r.wide) ^ fi.cy;
            if (r.operation == OP_SHR1) f.v = top_bit(a, r.wide);
            if (r.operation == OP_SHRA1) f.v = 1'b0;
            psz = r.operation inside {OP_SHR1, OP_SHRA1};
        end
        OP_SHL: begin
            t17  = {1'b0, a} << n;
            res  = t17[15:0];
            f.cy = (n >= 5'd16) ? 1'b0 : t17[w];
            psz  = 1'b1;
        end
        OP_SHR: begin
            res  = a >> n;
            f.cy = (n == 5'd0) ? 1'b0 : ((n <= w) ? a[n-1] : 1'b0);
            psz  = 1'b1;
        end
        OP_SHRA: begin
            sx   = r.wide ? $signed({{16{a[15]}}, a}) : $signed({{24{a[7]}}, a[7:0]});
            sx   = sx >>> n;
            res  = sx[15:0];
            f.cy = (n == 5'd0) ? 1'b0 : ((n <= w) ? a[n-1] : top_bit(a, r.wide));
            f.v  = 1'b0;
            psz  = 1'b1;
        end
        default: valid = 1'b0;
    endcase
    res = trim(res, r.wide);
    if (psz) begin
        f.p = ~^res[7:0];                             // Even parity.
        f.s = top_bit(res, r.wide);
    end
    if (psz || zonly) f.z = res == 16'h0000;
    e = '{valid: valid, res: res, flags: f};
    return e;
endfunction

`endif

// File: bench/tb_alu.sv
`timescale 1ns/1ns

module tb_alu;
    import alu_pkg::*;
    `include "alu_model.svh"

    localparam int NUM_REQ     = 4000;
    localparam int CYCLE_LIMIT = 20000;               // Bound on the request loop.
    localparam int DRAIN_LIMIT = 8;

    logic        clk;
    logic        reset;
    logic        execute;
    alu_req_t    req;
    alu_flags_t  flags_in;
    alu_word_t   result;
    alu_flags_t  flags;
    logic        done;

    logic [31:0] seed = 32'h522632bb;
    expect_t     expect_q[$];                         // Expected outcomes in request order.
    logic        done_due;
    alu_word_t   last_result;
    alu_flags_t  last_flags;
    int          sent;
    int          cycles;
    int          drain_wait;

    alu i_alu (
        .clk      (clk),
        .reset    (reset),
        .execute  (execute),
        .req      (req),
        .flags_in (flags_in),
        .result   (result),
        .flags    (flags),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ##############################
    // Helpers
    // ##############################

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL time=%0t signal=%s got=%0h expected=%0h",
                                $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic drive_request();
        logic [31:0] r1;
        logic [31:0] r2;
        int          code;
        expect_t     e;
        r1 = next_rand();
        r2 = next_rand();
        code = int'(next_rand() >> 8) % 28;
        req.ta = r1[31:16];
        req.tb = r1[15:0];
        case (r2[3:0])                                // Corner operands now and then.
            4'h0: req.ta = 16'h0000;
            4'h1: req.ta = 16'h8000;
            4'h2: req.ta = 16'h0080;
            4'h3: req.ta = 16'hffff;
            default: ;
        endcase
        flags_in = r2[21:16];
        req.wide = r2[22];
        if (r2[29:26] == 4'h0) begin
            req.operation = alu_op_e'(5'd28 + {3'b000, r2[24:23]});  // Invalid code.
        end else begin
            req.operation = alu_op_e'(code[4:0]);
        end
        execute  = r2[31:30] != 2'b00;                // About three quarters of cycles.
        e        = model_alu(req, flags_in);
        done_due = execute && e.valid;
        if (done_due) expect_q.push_back(e);
        if (execute) sent++;
    endtask

    task automatic check_outputs();
        expect_t e;
        check_value("done", done, done_due);
        if (done) begin
            e = expect_q.pop_front();
            check_value("result", result, e.res);
            check_value("flags", flags, e.flags);
            last_result = e.res;
            last_flags  = e.flags;
        end else begin
            check_value("result", result, last_result);   // Holds without done.
            check_value("flags", flags, last_flags);
        end
    endtask

    // ##############################
    // Stimulus
    // ##############################

    initial begin
        reset       = 1'b1;
        execute     = 1'b0;
        req         = '0;
        flags_in    = '0;
        done_due    = 1'b0;
        last_result = '0;
        last_flags  = '0;
        sent        = 0;
        cycles      = 0;
        drain_wait  = 0;
        repeat (5) @(posedge clk);
        #10 reset = 1'b0;
        @(posedge clk);
        #10;
        check_outputs();                              // Outputs are clear after reset.
        while (sent < NUM_REQ) begin
            drive_request();
            @(posedge clk);
            #10;
            check_outputs();
            cycles++;
            if (cycles > CYCLE_LIMIT) abort_run("request loop ran past its cycle limit");
        end
        execute  = 1'b0;
        done_due = 1'b0;
        while (expect_q.size() != 0 && drain_wait < DRAIN_LIMIT) begin
            @(posedge clk);
            #10;
            check_outputs();
            drain_wait++;
        end
        if (expect_q.size() != 0) begin
            abort_run("timed out waiting for outstanding requests to complete");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+include
src/alu_pkg.sv
src/alu_add_sub.sv
src/alu_logic.sv
src/alu_shift_rotate.sv
src/alu.sv
bench/tb_alu.sv

// File: src/alu.sv
`timescale 1ns/1ns

module alu (
    input  logic                clk,
    input  logic                reset,
    input  logic                execute,
    input  alu_pkg::alu_req_t   req,
    input  alu_pkg::alu_flags_t flags_in,
    output alu_pkg::alu_word_t  result,
    output alu_pkg::alu_flags_t flags,
    output logic                done
);
    import alu_pkg::*;

    alu_unit_out_t add_sub_out;
    alu_unit_out_t logic_out;
    alu_unit_out_t shift_out;
    alu_unit_out_t sel_out;                           // Output of the unit that hit.
    logic          any_hit;
    logic          res_zero;
    alu_flags_t    next_flags;
    logic          accept;

    // ############################
    // Units
    // ############################

    alu_add_sub i_add_sub (
        .req      (req),
        .flags_in (flags_in),
        .out      (add_sub_out)
    );

    alu_logic i_logic (
        .req      (req),
        .flags_in (flags_in),
        .out      (logic_out)
    );

    alu_shift_rotate i_shift_rotate (
        .req      (req),
        .flags_in (flags_in),
        .out      (shift_out)
    );

    assign any_hit = add_sub_out.hit | logic_out.hit | shift_out.hit;
    assign accept  = execute & any_hit;              // Invalid opcodes are ignored.

    always_comb begin
        if (add_sub_out.hit) begin
            sel_out = add_sub_out;
        end else if (logic_out.hit) begin
            sel_out = logic_out;
        end else begin
            sel_out = shift_out;
        end
    end

    // ############################
    // Parity, sign and zero
    // ############################

    assign res_zero = sel_out.res == '0;             // Upper byte already clear in byte mode.

    always_comb begin
        next_flags = sel_out.flags;
        if (sel_out.upd_psz) begin
            next_flags.p = ~^sel_out.res[BYTE_WIDTH-1:0];
            next_flags.s = word_msb(sel_out.res, req.wide);
        end
        if (sel_out.upd_psz || sel_out.upd_z) begin
            next_flags.z = res_zero;
        end
    end

    // ############################
    // Output registers
    // ############################

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
            done   <= 1'b0;
        end else begin
            done <= accept;
            if (accept) begin
                result <= sel_out.res;
                flags  <= next_flags;
            end
        end
    end

    // The units must keep the upper byte clear for byte requests.
    a_byte_upper_zero: assert property (
        @(posedge clk) disable iff (reset)
        (done && !$past(req.wide)) |-> (result[ALU_WIDTH-1:BYTE_WIDTH] == '0)
    ) else $error("byte result has a nonzero upper byte");

    a_single_hit: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0({add_sub_out.hit, logic_out.hit, shift_out.hit})
    ) else $error("more than one unit claimed the opcode");

endmodule

// File: src/alu_add_sub.sv
`timescale 1ns/1ns

module alu_add_sub (
    input  alu_pkg::alu_req_t      req,
    input  alu_pkg::alu_flags_t    flags_in,
    output alu_pkg::alu_unit_out_t out
);
    import alu_pkg::*;

    alu_word_t          a;                            // Operand A within the width.
    alu_word_t          b;                            // Operand B within the width.
    alu_word_t          operand;                      // Effective second operand.
    logic [ALU_WIDTH:0] sum;
    logic [4:0]         nib_sum;                      // Low nibble sum for AC.
    alu_word_t          diff;
    alu_word_t          neg;
    alu_word_t          res;
    logic               a_msb;
    logic               op_msb;
    logic               sum_msb;
    logic               diff_msb;
    logic               hit;
    alu_flags_t         f;

    assign a = fit_width(req.ta, req.wide);
    assign b = fit_width(req.tb, req.wide);

    always_comb begin
        case (req.operation)
            OP_INC, OP_DEC:   operand = alu_word_t'(1);
            OP_ADDC, OP_SUBC: operand = b + {{(ALU_WIDTH-1){1'b0}}, flags_in.cy}; // Wraps.
            default:          operand = b;
        endcase
    end

    // ############################
    // Datapath
    // ############################

    assign sum      = {1'b0, a} + {1'b0, operand};
    assign nib_sum  = {1'b0, a[3:0]} + {1'b0, operand[3:0]};
    assign diff     = a - operand;
    assign neg      = alu_word_t'(0) - a;
    assign a_msb    = word_msb(a, req.wide);
    assign op_msb   = word_msb(operand, req.wide);
    assign sum_msb  = word_msb(sum[ALU_WIDTH-1:0], req.wide);
    assign diff_msb = word_msb(diff, req.wide);

    always_comb begin
        f   = flags_in;                               // Untouched flags pass through.
        res = a;
        hit = 1'b1;
        case (req.operation)
            OP_ADD, OP_ADDC, OP_INC: begin
                res = sum[ALU_WIDTH-1:0];
                if (req.operation != OP_INC) begin
                    f.cy = req.wide ? sum[ALU_WIDTH] : sum[BYTE_WIDTH];
                end
                f.ac = nib_sum[4];
                f.v  = (a_msb ^ sum_msb) & (op_msb ^ sum_msb);
            end
            OP_SUB, OP_SUBC, OP_CMP, OP_DEC: begin
                res = diff;                           // CMP also returns the difference.
                if (req.operation != OP_DEC) begin
                    f.cy = operand > a;               // Borrow.
                end
                f.ac = operand[3:0] > a[3:0];
                f.v  = (a_msb ^ op_msb) & (a_msb ^ diff_msb);
            end
            OP_NEG: begin
                res  = neg;
                f.cy = a != '0;
                f.ac = a[3:0] != 4'h0;
                f.v  = req.wide ? (a == 16'h8000) : (a[BYTE_WIDTH-1:0] == 8'h80);
            end
            default: hit = 1'b0;
        endcase
    end

    assign out = '{res: fit_width(res, req.wide), flags: f, hit: hit,
                   upd_psz: hit, upd_z: 1'b0};

endmodule

// File: src/alu_logic.sv
`timescale 1ns/1ns

module alu_logic (
    input  alu_pkg::alu_req_t      req,
    input  alu_pkg::alu_flags_t    flags_in,
    output alu_pkg::alu_unit_out_t out
);
    import alu_pkg::*;

    alu_word_t  a;
    alu_word_t  mask;                                 // One-hot bit select.
    logic [3:0] bit_sel;
    logic       is_bitwise;
    alu_word_t  res;
    alu_flags_t f;
    logic       hit;
    logic       upd_psz;
    logic       upd_z;

    assign a          = fit_width(req.ta, req.wide);
    assign bit_sel    = req.wide ? req.tb[3:0] : {1'b0, req.tb[2:0]};
    assign mask       = alu_word_t'(1) << bit_sel;
    assign is_bitwise = req.operation inside {OP_AND, OP_OR, OP_XOR};

    always_comb begin
        f       = flags_in;
        res     = a;
        hit     = 1'b1;
        upd_psz = 1'b0;
        upd_z   = 1'b0;
        case (req.operation)
            OP_AND:  res = a & req.tb;
            OP_OR:   res = a | req.tb;
            OP_XOR:  res = a ^ req.tb;
            OP_NOT:  res = ~a;                        // No flag changes.
            OP_SET1: res = a | mask;
            OP_CLR1: res = a & ~mask;
            OP_NOT1: res = a ^ mask;
            OP_TEST1: begin
                res   = a & mask;
                f.cy  = 1'b0;
                f.v   = 1'b0;
                upd_z = 1'b1;
            end
            default: hit = 1'b0;
        endcase

        // AND, OR and XOR share the flag behavior.
        if (is_bitwise) begin
            f.cy    = 1'b0;
            f.v     = 1'b0;
            f.ac    = 1'b0;
            upd_psz = 1'b1;
        end
    end

    assign out = '{res: fit_width(res, req.wide), flags: f, hit: hit,
                   upd_psz: upd_psz, upd_z: upd_z};

endmodule

// File: src/alu_pkg.sv
package alu_pkg;

    // ############################
    // Widths
    // ############################

    localparam int ALU_WIDTH   = 16;                  // Word width.
    localparam int BYTE_WIDTH  = 8;                   // Byte width.
    localparam int COUNT_WIDTH = 5;                   // Bits of tb used as shift count.

    typedef logic [ALU_WIDTH-1:0] alu_word_t;

    // ############################
    // Operations
    // ############################

    // Codes 28 to 31 are left unused and count as invalid.
    typedef enum logic [4:0] {
        OP_ADD, OP_ADDC, OP_INC, OP_SUB, OP_SUBC, OP_CMP, OP_DEC, OP_NEG,
        OP_AND, OP_OR, OP_XOR, OP_NOT,
        OP_SET1, OP_CLR1, OP_TEST1, OP_NOT1,
        OP_ROL, OP_ROL1, OP_ROLC1, OP_ROR, OP_ROR1, OP_RORC1,
        OP_SHL, OP_SHL1, OP_SHR, OP_SHR1, OP_SHRA, OP_SHRA1
    } alu_op_e;

    typedef struct packed {
        logic cy;                                     // Carry.
        logic ac;                                     // Auxiliary carry out of bit 3.
        logic v;                                      // Signed overflow.
        logic p;                                      // Even parity of the low byte.
        logic s;                                      // Sign.
        logic z;                                      // Zero.
    } alu_flags_t;

    typedef struct packed {
        alu_op_e   operation;
        alu_word_t ta;
        alu_word_t tb;
        logic      wide;                              // 1 selects word, 0 selects byte.
    } alu_req_t;

    typedef struct packed {
        alu_word_t  res;                              // Upper byte zero in byte mode.
        alu_flags_t flags;
        logic       hit;                              // Unit owns the opcode.
        logic       upd_psz;                          // Recompute parity, sign and zero.
        logic       upd_z;                            // Recompute zero only.
    } alu_unit_out_t;

    // Most significant bit within the active width.
    function automatic logic word_msb(alu_word_t w, logic wide);
        return wide ? w[ALU_WIDTH-1] : w[BYTE_WIDTH-1];
    endfunction

    // Clears the upper byte in byte mode.
    function automatic alu_word_t fit_width(alu_word_t w, logic wide);
        return wide ? w : {{(ALU_WIDTH-BYTE_WIDTH){1'b0}}, w[BYTE_WIDTH-1:0]};
    endfunction

endpackage

// File: src/alu_shift_rotate.sv
`timescale 1ns/1ns

module alu_shift_rotate (
    input  alu_pkg::alu_req_t      req,
    input  alu_pkg::alu_flags_t    flags_in,
    output alu_pkg::alu_unit_out_t out
);
    import alu_pkg::*;

    alu_word_t                a;
    logic [COUNT_WIDTH-1:0]   n;                      // Shift or rotate count.
    logic [3:0]               rot;                    // Count modulo the width.
    logic                     msb;
    logic                     next_msb;
    logic                     lsb;
    alu_word_t                msb_bit;                // Position of the msb.
    logic [2*ALU_WIDTH-1:0]   dbl;                    // Operand placed twice.
    logic [2*ALU_WIDTH-1:0]   rot_l;
    logic [2*ALU_WIDTH-1:0]   rot_r;
    alu_word_t                rol_res;
    alu_word_t                ror_res;
    logic                     fill;                   // Bit entering a shift by one.
    alu_word_t                one_l;
    alu_word_t                one_r;
    logic [ALU_WIDTH:0]       shl_t;
    logic                     shl_cy;
    logic [ALU_WIDTH:0]       shr_t;                  // Bit 0 catches the last bit out.
    logic signed [ALU_WIDTH:0] sra_in;
    logic signed [ALU_WIDTH:0] sra_t;
    alu_word_t                res;
    alu_flags_t               f;
    logic                     hit;
    logic                     upd_psz;

    assign a        = fit_width(req.ta, req.wide);
    assign n        = req.tb[COUNT_WIDTH-1:0];
    assign rot      = req.wide ? n[3:0] : {1'b0, n[2:0]};
    assign msb      = word_msb(a, req.wide);
    assign next_msb = req.wide ? a[ALU_WIDTH-2] : a[BYTE_WIDTH-2];
    assign lsb      = a[0];
    assign msb_bit  = req.wide ? alu_word_t'(1) << (ALU_WIDTH-1)
                               : alu_word_t'(1) << (BYTE_WIDTH-1);

    // ############################
    // Rotates by count
    // ############################

    assign dbl = req.wide ? {a, a}
                          : {{ALU_WIDTH{1'b0}}, a[BYTE_WIDTH-1:0], a[BYTE_WIDTH-1:0]};
    assign rot_l = dbl << rot;
    assign rot_r = dbl >> rot;

    assign rol_res = req.wide ? rot_l[2*ALU_WIDTH-1:ALU_WIDTH]
                              : {{(ALU_WIDTH-BYTE_WIDTH){1'b0}},
                                 rot_l[2*BYTE_WIDTH-1:BYTE_WIDTH]};
    assign ror_res = fit_width(rot_r[ALU_WIDTH-1:0], req.wide);

    // ############################
    // Shifts and rotates by one
    // ############################

    always_comb begin
        case (req.operation)
            OP_ROL1, OP_SHRA1:  fill = msb;
            OP_ROR1:            fill = lsb;
            OP_ROLC1, OP_RORC1: fill = flags_in.cy;
            default:            fill = 1'b0;      // SHL1 and SHR1.
        endcase
    end

    assign one_l = {a[ALU_WIDTH-2:0], fill};      // Bit 8 is dropped in byte mode.
    assign one_r = (a >> 1) | (fill ? msb_bit : '0);

    // ############################
    // Shifts by count
    // ############################

    assign shl_t  = {1'b0, a} << n;
    assign shl_cy = (n >= ALU_WIDTH) ? 1'b0 : (req.wide ? shl_t[ALU_WIDTH] : shl_t[BYTE_WIDTH]);
    assign shr_t  = {a, 1'b0} >> n;
    assign sra_in = req.wide ? {a, 1'b0}
                             : {{(ALU_WIDTH-BYTE_WIDTH){a[BYTE_WIDTH-1]}},
                                a[BYTE_WIDTH-1:0], 1'b0};
    assign sra_t  = sra_in >>> n;

    always_comb begin
        f       = flags_in;
        res     = a;
        hit     = 1'b1;
        upd_psz = 1'b0;
        case (req.operation)
            OP_ROL: begin
                res  = rol_res;
                f.cy = rol_res[0];
            end
            OP_ROR: begin
                res  = ror_res;
                f.cy = word_msb(ror_res, req.wide);
            end
            OP_ROL1, OP_ROLC1, OP_SHL1: begin
                res     = one_l;
                f.cy    = msb;
                f.v     = msb ^ next_msb;
                upd_psz = req.operation == OP_SHL1;
            end
            OP_ROR1, OP_RORC1, OP_SHR1, OP_SHRA1: begin
                res     = one_r;
                f.cy    = lsb;
                upd_psz = req.operation inside {OP_SHR1, OP_SHRA1};
                case (req.operation)
                    OP_ROR1:  f.v = msb ^ lsb;
                    OP_RORC1: f.v = msb ^ flags_in.cy;
                    OP_SHR1:  f.v = msb;
                    default:  f.v = 1'b0;
                endcase
            end
            OP_SHL: begin
                res     = shl_t[ALU_WIDTH-1:0];
                f.cy    = shl_cy;
                upd_psz = 1'b1;
            end
            OP_SHR: begin
                res     = shr_t[ALU_WIDTH:1];
                f.cy    = shr_t[0];
                upd_psz = 1'b1;
            end
            OP_SHRA: begin
                res     = sra_t[ALU_WIDTH:1];
                f.cy    = sra_t[0];                   // Sign once the count passes the width.
                f.v     = 1'b0;
                upd_psz = 1'b1;
            end
            default: hit = 1'b0;
        endcase
    end

    assign out = '{res: fit_width(res, req.wide), flags: f, hit: hit,
                   upd_psz: upd_psz, upd_z: 1'b0};

endmodule
